/* filelist.f */
+incdir+src
src/switch_pkg.sv
src/sync_fifo.sv
src/rmii_receive_port.sv
src/cam_table.sv
src/forwarding_engine.sv
src/rmii_transmit_port.sv
src/switch_core.sv
tb/tb_switch_core.sv

/* run.sh */
#!/bin/sh
# Build and run the switch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_switch_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_switch_core 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

/* tb/tb_switch_core.sv */
`timescale 1ns/1ns
`default_nettype none
`include "switch_settings.svh"

module tb_switch_core;
    import switch_pkg::*;

    localparam int num_ports   = `SW_NUM_PORTS;
    localparam int cycle_limit = 12 * 40 * 4 * 3 + 2000;

    localparam mac_addr_t mac_a     = 48'h02_00_00_00_00_0a;
    localparam mac_addr_t mac_b     = 48'h02_00_00_00_00_0b;
    localparam mac_addr_t mac_c     = 48'h02_00_00_00_00_0c;
    localparam mac_addr_t mac_d     = 48'h02_00_00_00_00_0d;
    localparam mac_addr_t mac_e     = 48'h02_00_00_00_00_0e;
    localparam mac_addr_t mac_bcast = 48'hff_ff_ff_ff_ff_ff;
    localparam mac_addr_t mac_mcast = 48'h01_00_5e_00_00_01;

    logic                       clock;
    logic                       arst_n;
    rmii_rx_t [num_ports-1:0]   rmii_rx;
    wire rmii_tx_t [num_ports-1:0] rmii_tx;

    logic [7:0]  exp_q [num_ports][$];
    mac_addr_t   station_mac [$];
    port_idx_t   station_port [$];
    string       test_name;
    logic        first_sent;
    int unsigned cycles = 0;

    switch_core dut (
        .clock   (clock),
        .arst_n  (arst_n),
        .rmii_rx (rmii_rx),
        .rmii_tx (rmii_tx)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles", cycle_limit));
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input int port, input logic [7:0] expected,
                                   input logic [7:0] actual);
        fail_run($sformatf("[ERROR] %s port %0d expected 0x%02h actual 0x%02h",
                           test_name, port, expected, actual));
    endtask

    ////////////////////////////////////////
    // Learned-address model
    ////////////////////////////////////////
    function automatic int find_station(input mac_addr_t mac);
        for (int i = 0; i < station_mac.size(); i++) begin
            if (station_mac[i] == mac) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic void learn_station(input mac_addr_t mac, input port_idx_t port);
        int idx;
        idx = find_station(mac);
        // Group addresses are never learned
        if (!mac[40]) begin
            if (idx < 0) begin
                station_mac.push_back(mac);
                station_port.push_back(port);
            end else begin
                station_port[idx] = port;
            end
        end
    endfunction

    // Lookup sees the table from before this frame's own learn
    function automatic port_mask_t expected_mask(input port_idx_t port, input mac_addr_t dst,
                                                 input mac_addr_t src);
        int idx;
        idx = find_station(dst);
        if (src[40]) begin
            return '0;
        end
        if (idx < 0) begin
            return ~(port_mask_t'(1) << port);
        end
        if (station_port[idx] == port) begin
            return '0;
        end
        return port_mask_t'(1) << station_port[idx];
    endfunction

    function automatic int frame_len();
        return int'($urandom % 28) + 13;
    endfunction

    function automatic logic outputs_idle();
        logic idle;
        idle = (dut.frame_ready == '0);
        for (int q = 0; q < num_ports; q++) begin
            if (exp_q[q].size() != 0 || rmii_tx[q].valid) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    task automatic wait_idle();
        // Interframe gap, then wait for the switch to settle
        repeat (4) @(posedge clock);
        @(negedge clock);
        while (!outputs_idle()) begin
            @(negedge clock);
        end
    endtask

    task automatic send_frame(input string name, input port_idx_t port, input mac_addr_t dst,
                              input mac_addr_t src, input int len, input logic with_error);
        logic [7:0] bytes [$];
        port_mask_t mask;
        test_name = name;
        for (int i = 0; i < len; i++) begin
            if (i < 6) begin
                bytes.push_back(dst[47 - 8 * i -: 8]);
            end else if (i < 12) begin
                bytes.push_back(src[47 - 8 * (i - 6) -: 8]);
            end else begin
                bytes.push_back(8'($urandom));
            end
        end
        mask = '0;
        if (!with_error && len >= `SW_MIN_FRAME_BYTES) begin
            mask = expected_mask(port, dst, src);
            learn_station(src, port);
        end
        for (int q = 0; q < num_ports; q++) begin
            if (mask[q]) begin
                foreach (bytes[i]) begin
                    exp_q[q].push_back(bytes[i]);
                end
            end
        end
        first_sent = 1'b1;
        for (int i = 0; i < len; i++) begin
            for (int d = 0; d < 4; d++) begin
                @(posedge clock);
                rmii_rx[port] <= '{dibit: bytes[i][2 * d +: 2], data_enable: 1'b1,
                                   error: with_error && (i == len / 2)};
            end
        end
        @(posedge clock);
        rmii_rx[port] <= '0;
        wait_idle();
    endtask

    ////////////////////////////////////////
    // Output monitors
    ////////////////////////////////////////
    genvar p;
    generate
        for (p = 0; p < num_ports; p++) begin : g_monitor
            logic [5:0] shift;
            logic [1:0] dib_cnt;
            logic       byte_seen;
            logic       extra;
            logic [7:0] got;
            logic [7:0] expected;

            always @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                    dib_cnt   <= '0;
                    byte_seen <= 1'b0;
                    extra     <= 1'b0;
                end else begin
                    byte_seen <= 1'b0;
                    if (rmii_tx[p].valid) begin
                        shift   <= {rmii_tx[p].dibit, shift[5:2]};
                        dib_cnt <= dib_cnt + 1'b1;
                        if (dib_cnt == 2'd3) begin
                            byte_seen <= 1'b1;
                            got       <= {rmii_tx[p].dibit, shift};
                            if (exp_q[p].size() > 0) begin
                                expected <= exp_q[p].pop_front();
                                extra    <= 1'b0;
                            end else begin
                                extra <= 1'b1;
                            end
                        end
                    end else begin
                        dib_cnt <= '0;
                    end
                end
            end

            assert property (@(posedge clock) disable iff (!arst_n)
                             !first_sent |-> !rmii_tx[p].valid)
                else fail_run($sformatf("Transmit valid on port %0d before any frame", p));

            assert property (@(posedge clock) disable iff (!arst_n) !(byte_seen && extra))
                else fail_run($sformatf("Unexpected byte 0x%02h on port %0d during %s",
                                        got, p, test_name));

            assert property (@(posedge clock) disable iff (!arst_n)
                             byte_seen && !extra |-> got == expected)
                else report_mismatch(p, expected, got);
        end
    endgenerate

    initial begin
        void'($urandom(32'h0bd63d77));
        arst_n     = 1'b0;
        rmii_rx    = '0;
        first_sent = 1'b0;
        repeat (16) @(posedge clock);
        arst_n <= 1'b1;
        // Quiet time with no traffic
        repeat (40) @(posedge clock);

        send_frame("flood_unknown", 2'd0, mac_b, mac_a, frame_len(), 1'b0);
        send_frame("broadcast_flood", 2'd1, mac_bcast, mac_b, frame_len(), 1'b0);
        send_frame("learned_unicast", 2'd2, mac_a, mac_c, frame_len(), 1'b0);
        send_frame("learned_unicast_b", 2'd3, mac_b, mac_d, frame_len(), 1'b0);
        send_frame("same_port_filter", 2'd0, mac_a, mac_e, frame_len(), 1'b0);
        send_frame("rx_error_drop", 2'd1, mac_c, mac_b, frame_len(), 1'b1);
        send_frame("runt_drop", 2'd2, mac_d, mac_c, 10, 1'b0);
        send_frame("after_drop", 2'd1, mac_c, mac_b, frame_len(), 1'b0);
        send_frame("station_move", 2'd3, mac_c, mac_a, frame_len(), 1'b0);
        send_frame("moved_unicast", 2'd1, mac_a, mac_b, frame_len(), 1'b0);
        send_frame("moved_unicast_b", 2'd2, mac_a, mac_c, frame_len(), 1'b0);
        send_frame("multicast_flood", 2'd0, mac_mcast, mac_e, frame_len(), 1'b0);

        @(negedge clock);
        if (outputs_idle()) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run("Expected bytes still pending at the end of the run");
        end
    end

endmodule

`default_nettype wire

/* src/switch_core.sv */
`timescale 1ns/1ns
`default_nettype none
`include "switch_settings.svh"

module switch_core (
    input  wire                                           clock,
    input  wire                                           arst_n,
    input  wire switch_pkg::rmii_rx_t [`SW_NUM_PORTS-1:0] rmii_rx,
    output wire switch_pkg::rmii_tx_t [`SW_NUM_PORTS-1:0] rmii_tx
);
    import switch_pkg::*;

    wire port_mask_t                         frame_ready;
    wire port_mask_t                         status_pop;
    wire port_mask_t                         word_pop;
    wire port_mask_t                         tx_ready;
    wire port_mask_t                         tx_valid;
    wire port_word_t [`SW_NUM_PORTS-1:0]     head_word;
    wire frame_status_t [`SW_NUM_PORTS-1:0]  head_status;
    wire port_word_t                         tx_word;
    wire                                     learn;
    wire                                     lookup;
    wire                                     lookup_done;
    wire                                     hit;
    wire mac_addr_t                          learn_mac;
    wire mac_addr_t                          lookup_mac;
    wire port_idx_t                          learn_port;
    wire port_idx_t                          hit_port;

    genvar i;

    generate
        for (i = 0; i < `SW_NUM_PORTS; i = i + 1) begin : g_port
            rmii_receive_port rmii_receive_port (
                .clock       (clock),
                .arst_n      (arst_n),
                .rx          (rmii_rx[i]),
                .status_pop  (status_pop[i]),
                .word_pop    (word_pop[i]),
                .frame_ready (frame_ready[i]),
                .head_word   (head_word[i]),
                .head_status (head_status[i])
            );

            rmii_transmit_port rmii_transmit_port (
                .clock   (clock),
                .arst_n  (arst_n),
                .tx_word (tx_word),
                .tx_load (tx_valid[i]),
                .ready   (tx_ready[i]),
                .tx      (rmii_tx[i])
            );
        end
    endgenerate

    forwarding_engine forwarding_engine (
        .clock       (clock),
        .arst_n      (arst_n),
        .frame_ready (frame_ready),
        .head_word   (head_word),
        .head_status (head_status),
        .status_pop  (status_pop),
        .word_pop    (word_pop),
        .learn       (learn),
        .learn_mac   (learn_mac),
        .learn_port  (learn_port),
        .lookup      (lookup),
        .lookup_mac  (lookup_mac),
        .lookup_done (lookup_done),
        .hit         (hit),
        .hit_port    (hit_port),
        .tx_ready    (tx_ready),
        .tx_word     (tx_word),
        .tx_valid    (tx_valid)
    );

    cam_table cam_table (
        .clock       (clock),
        .arst_n      (arst_n),
        .learn       (learn),
        .learn_mac   (learn_mac),
        .learn_port  (learn_port),
        .lookup      (lookup),
        .lookup_mac  (lookup_mac),
        .lookup_done (lookup_done),
        .hit         (hit),
        .hit_port    (hit_port)
    );

endmodule

`default_nettype wire

/* src/rmii_transmit_port.sv */
`timescale 1ns/1ns
`default_nettype none

module rmii_transmit_port (
    input  wire                         clock,
    input  wire                         arst_n,
    input  wire switch_pkg::port_word_t tx_word,
    input  wire                         tx_load,
    output logic                        ready,
    output switch_pkg::rmii_tx_t        tx
);

    logic       busy;
    logic       last_q;
    logic [1:0] dib_cnt;
    logic [5:0] shreg;

    // A byte may follow on the final dibit, except after the end of a frame
    assign ready = !busy || (dib_cnt == 2'd3 && !last_q);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            last_q  <= 1'b0;
            dib_cnt <= '0;
            tx      <= '0;
        end else if (tx_load) begin
            busy    <= 1'b1;
            last_q  <= tx_word.last;
            dib_cnt <= '0;
            tx      <= '{dibit: tx_word.data[1:0], valid: 1'b1};
        end else if (busy) begin
            dib_cnt  <= dib_cnt + 1'b1;
            tx.dibit <= shreg[1:0];
            if (dib_cnt == 2'd3) begin
                busy <= 1'b0;
                tx   <= '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (tx_load) begin
            shreg <= tx_word.data[7:2];
        end else begin
            shreg <= shreg >> 2;
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n) tx_load |-> ready);

endmodule

`default_nettype wire

/* src/forwarding_engine.sv */
`timescale 1ns/1ns
`default_nettype none
`include "switch_settings.svh"

module forwarding_engine (
    input  wire                                                clock,
    input  wire                                                arst_n,
    input  wire switch_pkg::port_mask_t                        frame_ready,
    input  wire switch_pkg::port_word_t [`SW_NUM_PORTS-1:0]    head_word,
    input  wire switch_pkg::frame_status_t [`SW_NUM_PORTS-1:0] head_status,
    output switch_pkg::port_mask_t                             status_pop,
    output switch_pkg::port_mask_t                             word_pop,
    output logic                                               learn,
    output switch_pkg::mac_addr_t                              learn_mac,
    output switch_pkg::port_idx_t                              learn_port,
    output logic                                               lookup,
    output switch_pkg::mac_addr_t                              lookup_mac,
    input  wire                                                lookup_done,
    input  wire                                                hit,
    input  wire switch_pkg::port_idx_t                         hit_port,
    input  wire switch_pkg::port_mask_t                        tx_ready,
    output switch_pkg::port_word_t                             tx_word,
    output switch_pkg::port_mask_t                             tx_valid
);
    import switch_pkg::*;

    localparam int hdr_bytes = `SW_HEADER_BYTES;
    localparam int cw        = $clog2(hdr_bytes);

    typedef enum logic [2:0] {
        st_select, st_status, st_drain, st_header,
        st_lookup, st_wait, st_replay, st_stream
    } state_t;

    state_t                     state;
    port_idx_t                  in_port;
    port_idx_t                  rr_ptr;
    port_idx_t                  sel_port;
    port_mask_t                 mask;
    port_mask_t                 in_onehot;
    port_word_t                 in_word;
    logic [cw-1:0]              hdr_cnt;
    logic [0:hdr_bytes-1][7:0]  hdr;
    logic                       all_ready;
    logic                       filter;

    assign in_word    = head_word[in_port];
    assign in_onehot  = port_mask_t'(1) << in_port;
    assign all_ready  = (tx_ready & mask) == mask;
    // Bytes 0 to 5 destination, 6 to 11 source
    assign lookup_mac = hdr[0:5];
    assign learn_mac  = hdr[6:11];
    assign learn_port = in_port;
    assign filter     = hdr[6][0] || (hit && hit_port == in_port);

    // Lowest offset from the round-robin pointer wins
    always_comb begin
        port_idx_t cand;
        sel_port = rr_ptr;
        for (int k = `SW_NUM_PORTS - 1; k >= 0; k--) begin
            cand = rr_ptr + port_idx_t'(k);
            if (frame_ready[cand]) begin
                sel_port = cand;
            end
        end
    end

    always_comb begin
        status_pop = '0;
        word_pop   = '0;
        tx_valid   = '0;
        tx_word    = '{last: 1'b0, data: hdr[hdr_cnt]};
        learn      = 1'b0;
        lookup     = 1'b0;
        case (state)
            st_status: status_pop = in_onehot;
            st_drain, st_header: word_pop = in_onehot;
            st_lookup: begin
                // Multicast sources are never learned
                learn  = !hdr[6][0];
                lookup = 1'b1;
            end
            st_replay: begin
                if (all_ready) begin
                    tx_valid = mask;
                end
            end
            st_stream: begin
                tx_word = in_word;
                if (all_ready) begin
                    tx_valid = mask;
                    word_pop = in_onehot;
                end
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_select;
            in_port <= '0;
            rr_ptr  <= '0;
            mask    <= '0;
            hdr_cnt <= '0;
        end else begin
            case (state)
                st_select: begin
                    if (|frame_ready) begin
                        in_port <= sel_port;
                        rr_ptr  <= sel_port + 1'b1;
                        state   <= st_status;
                    end
                end
                st_status: begin
                    hdr_cnt <= '0;
                    state   <= head_status[in_port].good ? st_header : st_drain;
                end
                st_drain: begin
                    if (in_word.last) begin
                        state <= st_select;
                    end
                end
                st_header: begin
                    hdr_cnt <= hdr_cnt + 1'b1;
                    if (hdr_cnt == cw'(hdr_bytes - 1)) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: state <= st_wait;
                st_wait: begin
                    if (lookup_done) begin
                        hdr_cnt <= '0;
                        if (filter) begin
                            state <= st_drain;
                        end else begin
                            mask  <= hit ? (port_mask_t'(1) << hit_port) : ~in_onehot;
                            state <= st_replay;
                        end
                    end
                end
                st_replay: begin
                    if (all_ready) begin
                        hdr_cnt <= hdr_cnt + 1'b1;
                        if (hdr_cnt == cw'(hdr_bytes - 1)) begin
                            state <= st_stream;
                        end
                    end
                end
                st_stream: begin
                    if (all_ready && in_word.last) begin
                        mask  <= '0;
                        state <= st_select;
                    end
                end
                default: state <= st_select;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_header) begin
            hdr[hdr_cnt] <= in_word.data;
        end
    end

    // Never echo a frame back out of its ingress port
    assert property (@(posedge clock) disable iff (!arst_n) (tx_valid & in_onehot) == '0);

endmodule

`default_nettype wire

/* src/cam_table.sv */
`timescale 1ns/1ns
`default_nettype none
`include "switch_settings.svh"

module cam_table (
    input  wire                        clock,
    input  wire                        arst_n,
    input  wire                        learn,
    input  wire switch_pkg::mac_addr_t learn_mac,
    input  wire switch_pkg::port_idx_t learn_port,
    input  wire                        lookup,
    input  wire switch_pkg::mac_addr_t lookup_mac,
    output logic                       lookup_done,
    output logic                       hit,
    output switch_pkg::port_idx_t      hit_port
);
    import switch_pkg::*;

    localparam int depth = `SW_CAM_DEPTH;
    localparam int iw    = $clog2(depth);

    logic [depth-1:0] valid;
    mac_addr_t        keys  [depth];
    port_idx_t        ports [depth];
    logic [iw-1:0]    rr_ptr;
    logic [iw-1:0]    learn_idx;
    logic [iw-1:0]    free_idx;
    logic [iw-1:0]    look_idx;
    logic [iw-1:0]    wr_idx;
    logic             learn_match;
    logic             has_free;
    logic             look_match;
    logic             dup;

    ////////////////////////////////////////
    // Parallel compare
    ////////////////////////////////////////
    always_comb begin
        learn_match = 1'b0;
        learn_idx   = '0;
        has_free    = 1'b0;
        free_idx    = '0;
        look_match  = 1'b0;
        look_idx    = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (valid[i] && keys[i] == learn_mac) begin
                learn_match = 1'b1;
                learn_idx   = iw'(i);
            end
            if (!valid[i]) begin
                has_free = 1'b1;
                free_idx = iw'(i);
            end
            if (valid[i] && keys[i] == lookup_mac) begin
                look_match = 1'b1;
                look_idx   = iw'(i);
            end
        end
    end

    // Existing key first, then a free slot, then round-robin victim
    assign wr_idx = learn_match ? learn_idx : (has_free ? free_idx : rr_ptr);

    always_ff @(posedge clock) begin
        if (learn) begin
            keys[wr_idx]  <= learn_mac;
            ports[wr_idx] <= learn_port;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid       <= '0;
            rr_ptr      <= '0;
            lookup_done <= 1'b0;
            hit         <= 1'b0;
            hit_port    <= '0;
        end else begin
            lookup_done <= lookup;
            if (lookup) begin
                hit      <= look_match;
                hit_port <= ports[look_idx];
            end
            if (learn) begin
                valid[wr_idx] <= 1'b1;
                if (!learn_match && !has_free) begin
                    rr_ptr <= rr_ptr + 1'b1;
                end
            end
        end
    end

    always_comb begin
        dup = 1'b0;
        for (int i = 0; i < depth; i++) begin
            for (int j = i + 1; j < depth; j++) begin
                if (valid[i] && valid[j] && keys[i] == keys[j]) begin
                    dup = 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n) !dup);

endmodule

`default_nettype wire

/* src/rmii_receive_port.sv */
`timescale 1ns/1ns
`default_nettype none
`include "switch_settings.svh"

module rmii_receive_port (
    input  wire                       clock,
    input  wire                       arst_n,
    input  wire switch_pkg::rmii_rx_t rx,
    input  wire                       status_pop,
    input  wire                       word_pop,
    output logic                      frame_ready,
    output switch_pkg::port_word_t    head_word,
    output switch_pkg::frame_status_t head_status
);
    import switch_pkg::*;

    localparam int min_bytes = `SW_MIN_FRAME_BYTES;

    logic                             de_q;
    logic [1:0]                       dib_cnt;
    logic [5:0]                       shreg;
    logic [7:0]                       hold;
    logic                             hold_valid;
    logic                             rx_err;
    logic                             overflow;
    logic [$clog2(min_bytes+1)-1:0]   byte_cnt;
    logic                             byte_done;
    logic                             frame_end;
    logic                             data_push;
    logic                             data_full;
    logic                             status_push;
    logic                             status_empty;
    logic                             status_full;
    port_word_t                       data_word;
    frame_status_t                    status_word;

    assign byte_done   = rx.data_enable && (dib_cnt == 2'd3);
    assign frame_end   = de_q && !rx.data_enable;
    // One byte held back so the final one can carry the last flag
    assign data_push   = hold_valid && (byte_done || frame_end) && !data_full;
    assign data_word   = '{last: frame_end, data: hold};
    assign status_push = frame_end && hold_valid;
    assign status_word = '{good: !rx_err && !overflow && !data_full && byte_cnt == min_bytes};
    assign frame_ready = !status_empty;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            de_q       <= 1'b0;
            dib_cnt    <= '0;
            hold_valid <= 1'b0;
            rx_err     <= 1'b0;
            overflow   <= 1'b0;
            byte_cnt   <= '0;
        end else begin
            de_q <= rx.data_enable;
            if (frame_end) begin
                dib_cnt    <= '0;
                hold_valid <= 1'b0;
                rx_err     <= 1'b0;
                overflow   <= 1'b0;
                byte_cnt   <= '0;
            end else if (rx.data_enable) begin
                dib_cnt <= dib_cnt + 1'b1;
                if (rx.error) begin
                    rx_err <= 1'b1;
                end
                if (byte_done) begin
                    hold_valid <= 1'b1;
                    if (byte_cnt != min_bytes) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                    if (hold_valid && data_full) begin
                        overflow <= 1'b1;
                    end
                end
            end
        end
    end

    // First dibit lands in the low bits
    always_ff @(posedge clock) begin
        if (rx.data_enable) begin
            shreg <= {rx.dibit, shreg[5:2]};
        end
        if (byte_done) begin
            hold <= {rx.dibit, shreg};
        end
    end

    sync_fifo #(.payload_t(port_word_t), .depth(`SW_DATA_FIFO_DEPTH)) data_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .push      (data_push),
        .push_data (data_word),
        .pop       (word_pop),
        .head      (head_word),
        .empty     (),
        .full      (data_full)
    );

    sync_fifo #(.payload_t(frame_status_t), .depth(`SW_STATUS_FIFO_DEPTH)) status_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .push      (status_push),
        .push_data (status_word),
        .pop       (status_pop),
        .head      (head_status),
        .empty     (status_empty),
        .full      (status_full)
    );

    // Engine must keep up with frame arrivals
    assert property (@(posedge clock) disable iff (!arst_n) status_push |-> !status_full);

endmodule

`default_nettype wire

/* src/sync_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  wire           clock,
    input  wire           arst_n,
    input  wire           push,
    input  wire payload_t push_data,
    input  wire           pop,
    output payload_t      head,
    output logic          empty,
    output logic          full
);

    localparam int aw = $clog2(depth);

    payload_t        mem [depth];
    logic [aw-1:0]   wr_ptr;
    logic [aw-1:0]   rd_ptr;
    logic [aw:0]     count;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == (aw+1)'(depth));

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n) !(push && full));
    assert property (@(posedge clock) disable iff (!arst_n) !(pop && empty));

endmodule

`default_nettype wire

/* src/switch_pkg.sv */
`default_nettype none
`include "switch_settings.svh"

package switch_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [$clog2(`SW_NUM_PORTS)-1:0] port_idx_t;
    typedef logic [`SW_NUM_PORTS-1:0] port_mask_t;

    // 9-bit queue word with the flag on top of the byte
    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } port_word_t;

    typedef struct packed {
        logic good;
    } frame_status_t;

    typedef struct packed {
        logic [1:0] dibit;
        logic       data_enable;
        logic       error;
    } rmii_rx_t;

    typedef struct packed {
        logic [1:0] dibit;
        logic       valid;
    } rmii_tx_t;

endpackage

`default_nettype wire

/* src/switch_settings.svh */
`ifndef SWITCH_SETTINGS_SVH
`define SWITCH_SETTINGS_SVH

`define SW_NUM_PORTS         4
`define SW_CAM_DEPTH         16
`define SW_DATA_FIFO_DEPTH   128
`define SW_STATUS_FIFO_DEPTH 4

// Destination MAC then source MAC
`define SW_HEADER_BYTES      12
`define SW_MIN_FRAME_BYTES   13

`endif
